/* verilog/alut_pkg.sv */
// shared sizes, entry layout and control states of the address lookup table
// table size is fixed at 256 entries, one per value of the 8-bit MAC hash
// entry layout from the top bit down is valid | mac | port | stamp
// stamps and the time counter wrap at 32 bits, ages use modular subtraction
package alut_pkg;

   // ------------------------------------------------------------------------
   // table geometry
   // ------------------------------------------------------------------------
   localparam int ADDR_W = 8;                     // hash width = table index
   localparam int DEPTH  = 256;                   // 2**ADDR_W entries
   localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(DEPTH - 1); // end of a scan

   // field widths
   localparam int MAC_W     = 48;
   localparam int MAC_BYTES = MAC_W / 8;          // bytes folded by the hash
   localparam int PORT_W    = 2;                  // four switch ports
   localparam int STAMP_W   = 32;                 // stamp and time counter

   // ------------------------------------------------------------------------
   // entry layout
   // ------------------------------------------------------------------------
   localparam int ENTRY_W   = 1 + MAC_W + PORT_W + STAMP_W; // 83 bits

   // lowest bit of each field, stamp sits at the bottom
   localparam int STAMP_LSB = 0;                  // bits 31..0
   localparam int PORT_LSB  = STAMP_LSB + STAMP_W; // bits 33..32
   localparam int MAC_LSB   = PORT_LSB + PORT_W;   // bits 81..34
   localparam int VALID_BIT = MAC_LSB + MAC_W;     // bit 82, top of entry

   // ------------------------------------------------------------------------
   // aging
   // ------------------------------------------------------------------------
   // an entry this many cycles old or older is dropped by a sweep
   localparam logic [STAMP_W-1:0] AGE_LIMIT = 32'd1000;

   // ------------------------------------------------------------------------
   // control states
   // ------------------------------------------------------------------------
   typedef enum logic [1:0] {
      ST_CLEAR,    // table wipe after reset
      ST_IDLE,     // waiting for a strobe
      ST_LOOKUP,   // address checker busy on one frame
      ST_SWEEP     // age checker walking the table
   } ctrl_state_e;

endpackage

/* verilog/alut_mem.sv */
// dual-port table memory, port a for the address checker, port b for aging
// each port does a write or a registered read per cycle, never both
// read data shows one cycle after the address, a write leaves it unchanged
// no reset, contents are undefined until the clear pass has run
module alut_mem
(
   input  logic                         pclk28,
   input  logic [alut_pkg::ADDR_W-1:0]  addr_a,   // address checker side
   input  logic                         we_a,
   input  logic [alut_pkg::ENTRY_W-1:0] wdata_a,
   output logic [alut_pkg::ENTRY_W-1:0] rdata_a,
   input  logic [alut_pkg::ADDR_W-1:0]  addr_b,   // age checker side
   input  logic                         we_b,
   input  logic [alut_pkg::ENTRY_W-1:0] wdata_b,
   output logic [alut_pkg::ENTRY_W-1:0] rdata_b
);

   logic [alut_pkg::ENTRY_W-1:0] mem_core [alut_pkg::DEPTH]; // entry storage

   // ------------------------------------------------------------------------
   // both ports in one process, so the array has a single writer
   // ------------------------------------------------------------------------
   always_ff @(posedge pclk28)
   begin
      if (we_a)
         mem_core[addr_a] <= wdata_a;      // learn
      else
         rdata_a <= mem_core[addr_a];      // lookup read
      if (we_b)
         mem_core[addr_b] <= wdata_b;      // clear or invalidate
      else
         rdata_b <= mem_core[addr_b];      // sweep read
   end

   // the two checkers are serialized by control, so they never write together
   // to one entry
   a_no_write_clash: assert property (@(posedge pclk28)
      (we_a && we_b) |-> (addr_a != addr_b));

endmodule

/* verilog/alut_addr_checker.sv */
// address checker, one frame per lookup_go, owns port a of the table
// go edge: capture macs and port, hash them
// edge 1: destination entry read, edge 2: result decided and source learned
// lookup_done rises on edge 3, res_port and res_bcast hold until the next frame
// a hash collision simply overwrites the older entry
module alut_addr_checker
(
   input  logic                         pclk28,
   input  logic                         rst_n,
   input  logic                         lookup_go,  // frame accepted this edge
   input  logic [alut_pkg::MAC_W-1:0]   src_mac,
   input  logic [alut_pkg::MAC_W-1:0]   dst_mac,
   input  logic [alut_pkg::PORT_W-1:0]  src_port,
   input  logic [alut_pkg::STAMP_W-1:0] now,        // time counter
   input  logic [alut_pkg::ENTRY_W-1:0] rdata_a,
   output logic [alut_pkg::ADDR_W-1:0]  addr_a,
   output logic                         we_a,
   output logic [alut_pkg::ENTRY_W-1:0] wdata_a,
   output logic                         lookup_done,
   output logic [alut_pkg::PORT_W-1:0]  res_port,   // learned egress port
   output logic                         res_bcast   // unknown destination
);

   // xor of all mac bytes gives the table index
   function automatic logic [alut_pkg::ADDR_W-1:0] mac_hash
      (input logic [alut_pkg::MAC_W-1:0] mac);
      logic [alut_pkg::ADDR_W-1:0] h;
      h = '0;
      for (int i = 0; i < alut_pkg::MAC_BYTES; i++)
         h ^= mac[8*i +: 8];
      return h;
   endfunction

   logic                        rd_stage;    // dst read on port a
   logic                        wr_stage;    // decide + learn
   logic                        out_stage;   // one more cycle to done
   logic [alut_pkg::ADDR_W-1:0] dst_hash;
   logic [alut_pkg::ADDR_W-1:0] src_hash;
   logic [alut_pkg::MAC_W-1:0]  dst_mac_q;
   logic [alut_pkg::MAC_W-1:0]  src_mac_q;
   logic [alut_pkg::PORT_W-1:0] src_port_q;
   logic                        hit;

   // ------------------------------------------------------------------------
   // pipeline control
   // ------------------------------------------------------------------------
   always_ff @(posedge pclk28)
   begin
      if (!rst_n)
      begin
         rd_stage    <= 1'b0;
         wr_stage    <= 1'b0;
         out_stage   <= 1'b0;
         lookup_done <= 1'b0;
      end
      else
      begin
         rd_stage    <= lookup_go;
         wr_stage    <= rd_stage;
         out_stage   <= wr_stage;
         lookup_done <= out_stage;   // res_valid at top
      end
   end

   // frame capture, payload only
   always_ff @(posedge pclk28)
   begin
      if (lookup_go)
      begin
         dst_hash   <= mac_hash(dst_mac);
         src_hash   <= mac_hash(src_mac);
         dst_mac_q  <= dst_mac;
         src_mac_q  <= src_mac;
         src_port_q <= src_port;
      end
   end

   // ------------------------------------------------------------------------
   // port a, read the destination first, then write the source
   // ------------------------------------------------------------------------
   assign addr_a  = wr_stage ? src_hash : dst_hash;
   assign we_a    = wr_stage;
   assign wdata_a = {1'b1, src_mac_q, src_port_q, now};   // stamped at write edge

   // valid entry with the full mac, not just the hash
   assign hit = rdata_a[alut_pkg::VALID_BIT] &&
                (rdata_a[alut_pkg::MAC_LSB +: alut_pkg::MAC_W] == dst_mac_q);

   // result, rdata_a still holds the dst read during the learn cycle
   always_ff @(posedge pclk28)
   begin
      if (wr_stage)
      begin
         res_port  <= hit ? rdata_a[alut_pkg::PORT_LSB +: alut_pkg::PORT_W] : '0;
         res_bcast <= !hit;                 // flood on miss
      end
   end

   // done rises on the third edge after the go edge, so it is sampled
   // on the fourth
   a_done_timing: assert property (@(posedge pclk28) disable iff (!rst_n)
      lookup_go |=> !lookup_done [*3] ##1 lookup_done);

endmodule

/* verilog/alut_age_checker.sv */
// age checker, owns port b of the table
// clear mode writes zero to one address per cycle, all 256 entries
// sweep mode reads entry k on edge 2k+1 and compares on edge 2k+2
// a stale entry is written back with only the valid bit dropped
// scan_done rises one edge after the last write or compare
module alut_age_checker
(
   input  logic                         pclk28,
   input  logic                         rst_n,
   input  logic                         clear_go,   // wipe the table
   input  logic                         sweep_go,   // age the table
   input  logic [alut_pkg::STAMP_W-1:0] now,        // time counter
   input  logic [alut_pkg::ENTRY_W-1:0] rdata_b,
   output logic [alut_pkg::ADDR_W-1:0]  addr_b,
   output logic                         we_b,
   output logic [alut_pkg::ENTRY_W-1:0] wdata_b,
   output logic                         scan_done
);

   logic                         clear_run;   // clear pass active
   logic                         sweep_run;   // sweep pass active
   logic                         cmp_phase;   // 0 read, 1 compare
   logic                         fin;         // last entry handled
   logic [alut_pkg::ADDR_W-1:0]  idx;         // entry under work
   logic [alut_pkg::STAMP_W-1:0] age;
   logic                         stale;
   logic                         last_addr;

   assign last_addr = (idx == alut_pkg::LAST_ADDR);

   // ------------------------------------------------------------------------
   // scan sequencer
   // ------------------------------------------------------------------------
   always_ff @(posedge pclk28)
   begin
      if (!rst_n)
      begin
         clear_run <= 1'b0;
         sweep_run <= 1'b0;
         cmp_phase <= 1'b0;
         fin       <= 1'b0;
         scan_done <= 1'b0;
         idx       <= '0;
      end
      else
      begin
         fin       <= 1'b0;
         scan_done <= fin;                  // one cycle pulse
         if (clear_go)
         begin
            clear_run <= 1'b1;
            idx       <= '0;
         end
         else if (sweep_go)
         begin
            sweep_run <= 1'b1;
            cmp_phase <= 1'b0;              // read entry 0 first
            idx       <= '0;
         end
         else if (clear_run)
         begin
            idx <= idx + 1'b1;              // one write per cycle
            if (last_addr)
            begin
               clear_run <= 1'b0;
               fin       <= 1'b1;
            end
         end
         else if (sweep_run)
         begin
            cmp_phase <= !cmp_phase;
            if (cmp_phase)
            begin
               idx <= idx + 1'b1;           // next entry after compare
               if (last_addr)
               begin
                  sweep_run <= 1'b0;
                  fin       <= 1'b1;
               end
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   // age rule, uses now at the compare edge, wraps cleanly
   // ------------------------------------------------------------------------
   assign age   = now - rdata_b[alut_pkg::STAMP_LSB +: alut_pkg::STAMP_W];
   assign stale = rdata_b[alut_pkg::VALID_BIT] && (age >= alut_pkg::AGE_LIMIT);

   // port b
   assign addr_b  = idx;
   assign we_b    = clear_run || (sweep_run && cmp_phase && stale);
   assign wdata_b = clear_run ? '0 : {1'b0, rdata_b[alut_pkg::VALID_BIT-1:0]};

   // control must wait for scan_done before starting another pass
   a_no_restart: assert property (@(posedge pclk28) disable iff (!rst_n)
      (clear_go || sweep_go) |-> !(clear_run || sweep_run || fin));

endmodule

/* verilog/alut_ctrl.sv */
// control FSM of the lookup table, serializes lookups, sweeps and the clear
// a strobe is taken on an edge where busy is low, pkt_valid beats age_sweep
// strobes seen while busy are dropped, nothing is queued
// busy drops in the cycle of the done pulse, so a new strobe can follow it
// now is 0 on the first edge after reset and wraps at 32 bits
module alut_ctrl
(
   input  logic                         pclk28,
   input  logic                         rst_n,
   input  logic                         pkt_valid,    // frame strobe
   input  logic                         age_sweep,    // sweep strobe
   input  logic                         lookup_done,
   input  logic                         scan_done,
   output logic                         busy,
   output logic                         lookup_go,
   output logic                         sweep_go,
   output logic                         clear_go,
   output logic [alut_pkg::STAMP_W-1:0] now,
   output logic                         sweep_done
);

   alut_pkg::ctrl_state_e state;
   alut_pkg::ctrl_state_e state_nxt;
   logic                  free;          // can take a strobe this edge

   // ------------------------------------------------------------------------
   // time counter
   // ------------------------------------------------------------------------
   always_ff @(posedge pclk28)
   begin
      if (!rst_n)
         now <= '0;
      else
         now <= now + 1'b1;              // free running
   end

   // ------------------------------------------------------------------------
   // acceptance
   // ------------------------------------------------------------------------
   // idle, or the running job reports done in this cycle
   always_comb
   begin
      case (state)
         alut_pkg::ST_IDLE:   free = 1'b1;
         alut_pkg::ST_LOOKUP: free = lookup_done;
         alut_pkg::ST_SWEEP:  free = scan_done;
         alut_pkg::ST_CLEAR:  free = scan_done;
         default:             free = 1'b0;
      endcase
   end

   assign busy       = !free;
   assign lookup_go  = free && pkt_valid;                 // lookup wins
   assign sweep_go   = free && !pkt_valid && age_sweep;   // sweep dropped on tie
   assign sweep_done = (state == alut_pkg::ST_SWEEP) && scan_done;

   // ------------------------------------------------------------------------
   // next state
   // ------------------------------------------------------------------------
   always_comb
   begin
      state_nxt = state;
      if (free)
      begin
         if (pkt_valid)
            state_nxt = alut_pkg::ST_LOOKUP;
         else if (age_sweep)
            state_nxt = alut_pkg::ST_SWEEP;
         else
            state_nxt = alut_pkg::ST_IDLE;
      end
   end

   always_ff @(posedge pclk28)
   begin
      if (!rst_n)
         state <= alut_pkg::ST_CLEAR;    // table is wiped before first use
      else
         state <= state_nxt;
   end

   // clear request, a single pulse on the first cycle out of reset
   always_ff @(posedge pclk28)
   begin
      if (!rst_n)
         clear_go <= 1'b1;
      else
         clear_go <= 1'b0;
   end

   // a done pulse must belong to the job that is running
   a_done_matches: assert property (@(posedge pclk28) disable iff (!rst_n)
      lookup_done |-> (state == alut_pkg::ST_LOOKUP));

endmodule

/* verilog/alut_top.sv */
// address lookup table of a four-port switch, learns sources, finds egress
// strobes are accepted only while busy is low, see the control FSM
// res_valid pulses once per accepted frame, sweep_done once per sweep
// the table is cleared after every reset, busy stays high until it is done
module alut_top
(
   input  logic                        pclk28,
   input  logic                        rst_n,
   input  logic                        pkt_valid,
   input  logic [alut_pkg::MAC_W-1:0]  src_mac,
   input  logic [alut_pkg::MAC_W-1:0]  dst_mac,
   input  logic [alut_pkg::PORT_W-1:0] src_port,
   input  logic                        age_sweep,
   output logic                        busy,
   output logic                        res_valid,
   output logic [alut_pkg::PORT_W-1:0] res_port,
   output logic                        res_bcast,
   output logic                        sweep_done
);

   // ------------------------------------------------------------------------
   // internal wiring
   // ------------------------------------------------------------------------
   logic                         lookup_go;
   logic                         sweep_go;
   logic                         clear_go;
   logic                         scan_done;
   logic [alut_pkg::STAMP_W-1:0] now;

   // port a, address checker
   logic [alut_pkg::ADDR_W-1:0]  addr_a;
   logic                         we_a;
   logic [alut_pkg::ENTRY_W-1:0] wdata_a;
   logic [alut_pkg::ENTRY_W-1:0] rdata_a;

   // port b, age checker
   logic [alut_pkg::ADDR_W-1:0]  addr_b;
   logic                         we_b;
   logic [alut_pkg::ENTRY_W-1:0] wdata_b;
   logic [alut_pkg::ENTRY_W-1:0] rdata_b;

   alut_ctrl u_ctrl (
      .pclk28      (pclk28),
      .rst_n       (rst_n),
      .pkt_valid   (pkt_valid),
      .age_sweep   (age_sweep),
      .lookup_done (res_valid),     // lookup done is the result strobe
      .scan_done   (scan_done),
      .busy        (busy),
      .lookup_go   (lookup_go),
      .sweep_go    (sweep_go),
      .clear_go    (clear_go),
      .now         (now),
      .sweep_done  (sweep_done)
   );

   alut_addr_checker u_addr_checker (
      .pclk28      (pclk28),
      .rst_n       (rst_n),
      .lookup_go   (lookup_go),
      .src_mac     (src_mac),
      .dst_mac     (dst_mac),
      .src_port    (src_port),
      .now         (now),
      .rdata_a     (rdata_a),
      .addr_a      (addr_a),
      .we_a        (we_a),
      .wdata_a     (wdata_a),
      .lookup_done (res_valid),
      .res_port    (res_port),
      .res_bcast   (res_bcast)
   );

   alut_age_checker u_age_checker (
      .pclk28    (pclk28),
      .rst_n     (rst_n),
      .clear_go  (clear_go),
      .sweep_go  (sweep_go),
      .now       (now),
      .rdata_b   (rdata_b),
      .addr_b    (addr_b),
      .we_b      (we_b),
      .wdata_b   (wdata_b),
      .scan_done (scan_done)
   );

   alut_mem u_mem (
      .pclk28  (pclk28),
      .addr_a  (addr_a),
      .we_a    (we_a),
      .wdata_a (wdata_a),
      .rdata_a (rdata_a),
      .addr_b  (addr_b),
      .we_b    (we_b),
      .wdata_b (wdata_b),
      .rdata_b (rdata_b)
   );

endmodule

/* sim/tb_alut.sv */
// random testbench of the address lookup table with one fixed seed
// a model table predicts every result from the xor of the six mac bytes
// each strobe goes out on the edge of the previous done so the DUT is idle
// extra strobes are pulsed while busy and must leave no trace
// stops at the first mismatch and a cycle budget guards against a hang
module tb_alut;
   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [31:0] SEED       = 32'hd3df_6aa9;
   localparam int          N_OPS      = 360;    // lookups plus sweeps
   localparam int          POOL       = 32;     // mac pool size
   localparam int          RES_EDGE   = 3;      // res_valid rises on edge 3 after accept
   localparam int          SWEEP_EDGE = 513;    // sweep_done rises on edge 513

   logic                         pclk28 = 1'b0;
   logic                         rst_n;
   logic                         pkt_valid;
   logic [alut_pkg::MAC_W-1:0]   src_mac;
   logic [alut_pkg::MAC_W-1:0]   dst_mac;
   logic [alut_pkg::PORT_W-1:0]  src_port;
   logic                         age_sweep;
   logic                         busy;
   logic                         res_valid;
   logic [alut_pkg::PORT_W-1:0]  res_port;
   logic                         res_bcast;
   logic                         sweep_done;

   // ------------------------------------------------------------------------
   // reference table and bookkeeping
   // ------------------------------------------------------------------------
   logic                         m_valid [alut_pkg::DEPTH];
   logic [alut_pkg::MAC_W-1:0]   m_mac   [alut_pkg::DEPTH];
   logic [alut_pkg::PORT_W-1:0]  m_port  [alut_pkg::DEPTH];
   logic [alut_pkg::STAMP_W-1:0] m_stamp [alut_pkg::DEPTH];
   logic [alut_pkg::STAMP_W-1:0] tnow;            // mirrors the DUT time counter

   logic [alut_pkg::MAC_W-1:0]   pool [$];
   bit                           sweep_q [$];     // op schedule, 1 is a sweep
   int unsigned                  cyc_cnt;
   int unsigned                  cycle_limit;
   int                           n_lookups;
   int                           n_sweeps;
   int                           n_res;           // res_valid pulses seen
   int                           n_sweep_done;
   int                           n_stale;         // entries aged out by the model

   alut_top dut0 (
      .pclk28     (pclk28),
      .rst_n      (rst_n),
      .pkt_valid  (pkt_valid),
      .src_mac    (src_mac),
      .dst_mac    (dst_mac),
      .src_port   (src_port),
      .age_sweep  (age_sweep),
      .busy       (busy),
      .res_valid  (res_valid),
      .res_port   (res_port),
      .res_bcast  (res_bcast),
      .sweep_done (sweep_done)
   );

   always #2 pclk28 = ~pclk28;          // 4 ns period

   // 0 on the first edge out of reset, like the DUT counter
   always @(posedge pclk28)
   begin
      if (!rst_n)
         tnow <= '0;
      else
         tnow <= tnow + 1;
   end

   // pulse counters and the hang guard
   always @(posedge pclk28)
   begin
      cyc_cnt <= cyc_cnt + 1;
      if (res_valid === 1'b1)
         n_res <= n_res + 1;
      if (sweep_done === 1'b1)
         n_sweep_done <= n_sweep_done + 1;
      if (cyc_cnt >= cycle_limit)
      begin
         $display("timeout: the run used up its budget of %0d cycles", cycle_limit);
         $display("TEST RESULT: FAIL");
         $fatal(1, "simulation did not finish in time");
      end
   end

   // ------------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------------
   function automatic logic [alut_pkg::ADDR_W-1:0] fold_hash
      (input logic [alut_pkg::MAC_W-1:0] mac);
      logic [7:0] h;
      h = mac[7:0] ^ mac[15:8] ^ mac[23:16] ^ mac[31:24] ^ mac[39:32] ^ mac[47:40];
      return h;
   endfunction

   task automatic check_eq(input logic [31:0] got, input logic [31:0] exp,
                           input string what);
      if (got !== exp)
      begin
         $display("FAILED at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
         $display("TEST RESULT: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   // called on the accepting edge, pokes a strobe that busy must block
   task automatic accept_strobe(output logic [alut_pkg::STAMP_W-1:0] acc_now);
      int inj;
      check_eq(32'(busy), 0, "busy at acceptance");
      acc_now   = tnow;
      inj       = $urandom_range(0, 7);
      pkt_valid <= (inj == 1 || inj == 3);
      age_sweep <= (inj == 2 || inj == 3);
      src_mac   <= pool[$urandom_range(0, POOL-1)];
      dst_mac   <= pool[$urandom_range(0, POOL-1)];
      src_port  <= 2'($urandom_range(0, 3));
      @(posedge pclk28);
      check_eq(32'(busy), 1, "busy while a job runs");
      pkt_valid <= 1'b0;
      age_sweep <= 1'b0;
   endtask

   task automatic lookup_op();
      logic [alut_pkg::MAC_W-1:0]   smac;
      logic [alut_pkg::MAC_W-1:0]   dmac;
      logic [alut_pkg::PORT_W-1:0]  port;
      logic [alut_pkg::ADDR_W-1:0]  hd;
      logic [alut_pkg::ADDR_W-1:0]  hs;
      logic                         hit;
      logic [alut_pkg::PORT_W-1:0]  exp_port;
      logic [alut_pkg::STAMP_W-1:0] acc_now;
      int                           lat;
      smac = pool[$urandom_range(0, POOL-1)];
      dmac = pool[$urandom_range(0, POOL-1)];
      port = 2'($urandom_range(0, 3));
      hd   = fold_hash(dmac);
      hs   = fold_hash(smac);
      // prediction uses the table before this frame learns
      hit      = m_valid[hd] && (m_mac[hd] == dmac);
      exp_port = hit ? m_port[hd] : '0;
      pkt_valid <= 1'b1;
      age_sweep <= ($urandom_range(0, 9) == 0);   // tie drops the sweep
      src_mac   <= smac;
      dst_mac   <= dmac;
      src_port  <= port;
      @(posedge pclk28);
      accept_strobe(acc_now);
      lat = 1;
      while (res_valid !== 1'b1)
      begin
         check_eq(32'(sweep_done), 0, "sweep_done during a lookup");
         @(posedge pclk28);
         lat++;
      end
      check_eq(lat, RES_EDGE + 1, "res_valid latency after acceptance");
      check_eq(32'(res_bcast), 32'(!hit), "res_bcast");
      check_eq(32'(res_port), 32'(exp_port), "res_port");
      m_valid[hs] = 1'b1;                  // collision replaces the older mac
      m_mac[hs]   = smac;
      m_port[hs]  = port;
      m_stamp[hs] = acc_now + 32'd2;       // written on edge 2
   endtask

   task automatic sweep_op();
      logic [alut_pkg::STAMP_W-1:0] acc_now;
      logic [alut_pkg::STAMP_W-1:0] cmp_now;
      logic [alut_pkg::ADDR_W-1:0]  a;
      int                           lat;
      int                           k;
      pkt_valid <= 1'b0;
      age_sweep <= 1'b1;
      @(posedge pclk28);
      accept_strobe(acc_now);
      lat = 1;
      while (sweep_done !== 1'b1)
      begin
         check_eq(32'(res_valid), 0, "res_valid during a sweep");
         @(posedge pclk28);
         lat++;
      end
      check_eq(lat, SWEEP_EDGE + 1, "sweep_done latency after acceptance");
      // entry k is judged with now as it is on edge 2k+2
      for (k = 0; k < alut_pkg::DEPTH; k++)
      begin
         a       = 8'(k);
         cmp_now = acc_now + 32'(2 * k + 2);
         if (m_valid[a] && (cmp_now - m_stamp[a]) >= alut_pkg::AGE_LIMIT)
         begin
            m_valid[a] = 1'b0;
            n_stale++;
         end
      end
   endtask

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------
   initial
   begin
      int         k;
      bit         prev;
      bit         sw;
      logic [7:0] b;
      void'($urandom(SEED));
      rst_n     <= 1'b0;
      pkt_valid <= 1'b0;
      age_sweep <= 1'b0;
      src_mac   <= '0;
      dst_mac   <= '0;
      src_port  <= '0;
      // upper half of the pool repeats the hashes of the lower half
      for (k = 0; k < POOL; k++)
      begin
         if (k < POOL / 2)
            pool.push_back({16'($urandom()), $urandom()});
         else
         begin
            b = 8'($urandom_range(1, 255));
            pool.push_back(pool[k - POOL / 2] ^ {b, 8'h00, b, 24'h000000});
         end
      end
      prev = 1'b0;
      for (k = 0; k < N_OPS; k++)
      begin
         sw = ($urandom_range(0, 29) == 0);
         if (prev && $urandom_range(0, 1) == 1)
            sw = 1'b1;                     // back to back sweeps age harder
         if (k == N_OPS / 2 || k == N_OPS / 2 + 1)
            sw = 1'b1;
         sweep_q.push_back(sw);
         prev = sw;
         if (sw)
            n_sweeps++;
         else
            n_lookups++;
      end
      cycle_limit = 300 + 6 * n_lookups + 520 * n_sweeps + 1000;
      for (k = 0; k < alut_pkg::DEPTH; k++)
         m_valid[8'(k)] = 1'b0;            // state after the clear pass
      repeat (10) @(posedge pclk28);
      rst_n <= 1'b1;
      @(posedge pclk28);
      while (busy !== 1'b0)
         @(posedge pclk28);                // clear pass still running
      for (k = 0; k < N_OPS; k++)
      begin
         if (sweep_q[k])
            sweep_op();
         else
            lookup_op();
      end
      repeat (4) @(posedge pclk28);
      check_eq(n_res, n_lookups, "res_valid pulse count");
      check_eq(n_sweep_done, n_sweeps, "sweep_done pulse count");
      $display("%0d lookups, %0d sweeps, %0d entries aged out",
               n_lookups, n_sweeps, n_stale);
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

/* files.f */
verilog/alut_pkg.sv
verilog/alut_mem.sv
verilog/alut_addr_checker.sv
verilog/alut_age_checker.sv
verilog/alut_ctrl.sv
verilog/alut_top.sv
sim/tb_alut.sv

/* Makefile */
# Verilator flow for the address lookup table
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_alut
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LINT_OPTS ?= --lint-only --timing
SIM_OPTS  ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_OPTS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass message shows up in its output
sim:
	$(VERILATOR) $(SIM_OPTS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
